// File: project.f
+incdir+logic
logic/sd_dat_pkg.sv
logic/dat_serializer.sv
logic/dat_deserializer.sv
logic/dat_phys_controller.sv
logic/dat_phys.sv
verification/sd_card_model.sv
verification/dat_phys_sva.sv
verification/dat_phys_tb.sv

// File: Bender.yml
package:
  name: sd_dat_phys

sources:
  - include_dirs:
      - logic
    files:
      - logic/sd_dat_pkg.sv
      - logic/dat_serializer.sv
      - logic/dat_deserializer.sv
      - logic/dat_phys_controller.sv
      - logic/dat_phys.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verification/sd_card_model.sv
      - verification/dat_phys_sva.sv
      - verification/dat_phys_tb.sv

// File: verification/dat_phys_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dat_phys_tb;
	import sd_dat_pkg::*;

	localparam logic [1:0] MODE_NORMAL = 2'd0;
	localparam logic [1:0] MODE_CORRUPT = 2'd1;
	localparam logic [1:0] MODE_REJECT = 2'd2;
	localparam logic [1:0] MODE_SILENT = 2'd3;
	// block that the card spoils in corrupt and reject mode
	localparam int BAD_BLOCK = 1;
	localparam int NUM_ROWS = 8;

	typedef struct packed {
		logic write_read;
		logic multiple;
		logic [3:0] blocks;
		logic [15:0] timeout;
		logic [1:0] mode;
		logic [7:0] stall;
		logic exp_timeout;
		logic exp_crc_error;
	} row_t;

	logic sd_clock = 1'b0;
	logic arst_n;
	logic strobe_in;
	logic ack_in;
	logic idle_in;
	logic write_read;
	logic multiple;
	logic status;
	timeout_t timeout_reg;
	blk_count_t blocks;
	dat_word_t data_from_fifo;
	dat_word_t data_to_fifo;
	logic serial_ready;
	logic complete;
	logic ack_out;
	logic data_timeout;
	logic crc_error;
	logic read_enable;
	logic write_enable;
	wire dat_pin;

	logic card_start;
	logic card_dir;
	logic [1:0] card_mode;
	logic [3:0] card_nblk;

	row_t rows [0:NUM_ROWS-1];
	dat_word_t words [0:15];
	dat_word_t stored [0:15];
	int rd_ptr;
	int store_cnt;
	int fifo_len;
	int stall_len;
	int stall_left;
	logic fifo_write_dir;
	integer seed;
	int cycles = 0;
	int cycle_limit = 0;
	int checks = 0;
	int errors = 0;

	pullup (dat_pin);

	always #50 sd_clock = ~sd_clock;

	dat_phys dat_phys_inst (
		.sd_clock(sd_clock),
		.arst_n(arst_n),
		.strobe_in(strobe_in),
		.ack_in(ack_in),
		.idle_in(idle_in),
		.timeout_reg(timeout_reg),
		.blocks(blocks),
		.write_read(write_read),
		.multiple(multiple),
		.status(status),
		.data_from_fifo(data_from_fifo),
		.serial_ready(serial_ready),
		.complete(complete),
		.ack_out(ack_out),
		.data_timeout(data_timeout),
		.crc_error(crc_error),
		.read_enable(read_enable),
		.write_enable(write_enable),
		.data_to_fifo(data_to_fifo),
		.dat_pin(dat_pin)
	);

	sd_card_model card_inst (
		.sd_clock(sd_clock),
		.start(card_start),
		.write_dir(card_dir),
		.mode(card_mode),
		.nblk(card_nblk),
		.bad_block(4'(BAD_BLOCK)),
		.rx_window(dat_phys_inst.rx_enable),
		.complete(complete),
		.dat_pin(dat_pin)
	);

	// status means empty on writes and full on reads
	// stall restarts after each access and while a frame or token comes in
	always @(posedge sd_clock) begin
		if (read_enable) begin
			data_from_fifo <= words[rd_ptr];
			rd_ptr = rd_ptr + 1;
		end
		if (write_enable) begin
			stored[store_cnt] = data_to_fifo;
			store_cnt = store_cnt + 1;
		end
		if (read_enable || write_enable || dat_phys_inst.rx_enable)
			stall_left = stall_len;
		else if (stall_left > 0)
			stall_left = stall_left - 1;
		status <= (stall_left > 0) || (fifo_write_dir && rd_ptr >= fifo_len);
	end

	always @(negedge sd_clock) begin
		if (arst_n) begin
			assert (!(status && (read_enable || write_enable))) else begin
				$display("FIFO accessed at %0t while status was high", $time);
				errors++;
			end
		end
	end

	always @(posedge sd_clock) begin
		cycles = cycles + 1;
		if (cycle_limit > 0 && cycles > cycle_limit) begin
			$display("run stopped after %0d cycles, a transfer never completed", cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	function automatic int block_count(input row_t r);
		return (r.multiple && r.blocks != 0) ? int'(r.blocks) : 1;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("FAIL %0t %s got %0h expected %0h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		checks++;
		assert (cond) else begin
			$display("at %0t: %s", $time, what);
			errors++;
		end
	endtask

	task automatic run_row(input int idx);
		row_t r;
		int nblk;
		int exp_frames;
		int exp_stores;
		int errs_before;
		int start_cyc;
		r = rows[idx];
		errs_before = errors;
		nblk = block_count(r);
		exp_frames = (r.mode == MODE_REJECT) ? BAD_BLOCK + 1 : nblk;
		exp_stores = (r.mode == MODE_CORRUPT) ? BAD_BLOCK :
			(r.mode == MODE_SILENT) ? 0 : nblk;
		@(negedge sd_clock);
		for (int i = 0; i < nblk; i++) begin
			words[i] = $random(seed);
			card_inst.tx_words[i] = words[i];
		end
		rd_ptr = 0;
		store_cnt = 0;
		fifo_len = r.write_read ? nblk : 0;
		stall_len = r.stall;
		stall_left = r.stall;
		fifo_write_dir = r.write_read;
		check_true(serial_ready, "serial_ready low before the strobe");
		@(posedge sd_clock);
		write_read <= r.write_read;
		multiple <= r.multiple;
		blocks <= r.blocks;
		timeout_reg <= r.timeout;
		strobe_in <= 1'b1;
		card_start <= 1'b1;
		card_dir <= r.write_read;
		card_mode <= r.mode;
		card_nblk <= 4'(nblk);
		@(posedge sd_clock);
		strobe_in <= 1'b0;
		card_start <= 1'b0;
		@(negedge sd_clock);
		start_cyc = cycles;
		while (!complete)
			@(negedge sd_clock);
		check_value("data_timeout", data_timeout, r.exp_timeout);
		check_value("crc_error", crc_error, r.exp_crc_error);
		if (r.exp_timeout)
			check_true(cycles - start_cyc >= r.timeout, "data_timeout came too early");
		@(posedge sd_clock);
		ack_in <= 1'b1;
		@(posedge sd_clock);
		ack_in <= 1'b0;
		@(negedge sd_clock);
		check_value("ack_out", ack_out, 1'b1);
		check_value("serial_ready", serial_ready, 1'b1);
		if (r.write_read) begin
			check_value("card frames", card_inst.frames_rx, exp_frames);
			check_value("card frame errors", card_inst.frame_errs, 0);
			for (int i = 0; i < exp_frames; i++)
				check_value("card word", card_inst.rx_words[i], words[i]);
		end else begin
			check_value("write_enable count", store_cnt, exp_stores);
			for (int i = 0; i < exp_stores; i++)
				check_value("data_to_fifo", stored[i], words[i]);
		end
		$display("row %0d %s, %0d blocks, card mode %0d: %0d errors", idx,
			r.write_read ? "write" : "read", nblk, r.mode, errors - errs_before);
	endtask

	initial begin
		seed = 32'he4f1_7723;
		arst_n = 1'b0;
		strobe_in = 1'b0;
		ack_in = 1'b0;
		idle_in = 1'b0;
		write_read = 1'b0;
		multiple = 1'b0;
		status = 1'b0;
		timeout_reg = '0;
		blocks = '0;
		data_from_fifo = '0;
		card_start = 1'b0;
		card_dir = 1'b0;
		card_mode = MODE_NORMAL;
		card_nblk = '0;
		rd_ptr = 0;
		store_cnt = 0;
		fifo_len = 0;
		stall_len = 0;
		stall_left = 0;
		fifo_write_dir = 1'b0;

		// write_read, multiple, blocks, timeout, card mode, stall, data_timeout, crc_error
		rows[0] = {1'b1, 1'b1, 4'd4, 16'd40, MODE_NORMAL, 8'd0, 1'b0, 1'b0};
		rows[1] = {1'b0, 1'b1, 4'd4, 16'd40, MODE_NORMAL, 8'd0, 1'b0, 1'b0};
		rows[2] = {1'b0, 1'b1, 4'd3, 16'd40, MODE_CORRUPT, 8'd0, 1'b0, 1'b1};
		rows[3] = {1'b1, 1'b1, 4'd3, 16'd40, MODE_REJECT, 8'd0, 1'b0, 1'b1};
		rows[4] = {1'b0, 1'b0, 4'd1, 16'd30, MODE_SILENT, 8'd0, 1'b1, 1'b0};
		rows[5] = {1'b1, 1'b1, 4'd3, 16'd40, MODE_NORMAL, 8'd5, 1'b0, 1'b0};
		rows[6] = {1'b0, 1'b1, 4'd3, 16'd40, MODE_NORMAL, 8'd5, 1'b0, 1'b0};
		// multiple low gives one block despite the count
		rows[7] = {1'b1, 1'b0, 4'd5, 16'd40, MODE_NORMAL, 8'd0, 1'b0, 1'b0};

		cycle_limit = 500;
		for (int i = 0; i < NUM_ROWS; i++)
			cycle_limit += block_count(rows[i]) *
				(50 + 8 + rows[i].timeout + rows[i].stall + 20) + 100;

		repeat (2) @(posedge sd_clock);
		arst_n <= 1'b1;
		@(negedge sd_clock);
		check_value("serial_ready", serial_ready, 1'b1);
		check_value("complete", complete, 1'b0);
		check_value("ack_out", ack_out, 1'b0);
		check_value("data_timeout", data_timeout, 1'b0);
		check_value("crc_error", crc_error, 1'b0);
		check_value("read_enable", read_enable, 1'b0);
		check_value("write_enable", write_enable, 1'b0);

		for (int i = 0; i < NUM_ROWS; i++)
			run_row(i);

		check_value("assertion failures", dat_phys_inst.sva_inst.fail_count, 0);
		$display("rows %0d, checks %0d, errors %0d", NUM_ROWS, checks, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verification/dat_phys_sva.sv
`timescale 1ns/1ps
`default_nettype none

module dat_phys_sva (
	input wire sd_clock,
	input wire arst_n,
	input wire ack_in,
	input wire idle_in,
	input wire ack_out,
	input wire complete,
	input wire read_enable,
	input wire write_enable,
	input wire dat_oe,
	input wire rx_enable
);

	int fail_count = 0;

	ack_out_pulse: assert property (@(posedge sd_clock) disable iff (!arst_n)
		ack_out |=> !ack_out)
		else begin
			$error("ack_out high for more than one cycle");
			fail_count++;
		end

	// only ack_in or an abort may end complete
	complete_held: assert property (@(posedge sd_clock) disable iff (!arst_n)
		complete && !ack_in && !idle_in |=> complete)
		else begin
			$error("complete dropped without ack_in");
			fail_count++;
		end

	fifo_one_way: assert property (@(posedge sd_clock) disable iff (!arst_n)
		!(read_enable && write_enable))
		else begin
			$error("read_enable and write_enable high together");
			fail_count++;
		end

	pad_released: assert property (@(posedge sd_clock) disable iff (!arst_n)
		rx_enable |-> !dat_oe)
		else begin
			$error("dat pad driven while receiving");
			fail_count++;
		end

endmodule

bind dat_phys dat_phys_sva sva_inst (
	.sd_clock(sd_clock),
	.arst_n(arst_n),
	.ack_in(ack_in),
	.idle_in(idle_in),
	.ack_out(ack_out),
	.complete(complete),
	.read_enable(read_enable),
	.write_enable(write_enable),
	.dat_oe(dat_oe),
	.rx_enable(rx_enable)
);

`default_nettype wire

// File: verification/sd_card_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "sd_dat_config.svh"

module sd_card_model (
	input wire sd_clock,
	input wire start,
	input wire write_dir,
	input wire [1:0] mode,
	input wire [3:0] nblk,
	input wire [3:0] bad_block,
	input wire rx_window,
	input wire complete,
	inout wire dat_pin
);
	localparam logic [1:0] MODE_CORRUPT = 2'd1;
	localparam logic [1:0] MODE_REJECT = 2'd2;
	localparam logic [1:0] MODE_SILENT = 2'd3;

	logic drv_en;
	logic drv_val;
	// words sent on reads, filled by the testbench
	logic [31:0] tx_words [0:15];
	// words taken from write frames
	logic [31:0] rx_words [0:15];
	int frames_rx;
	int frame_errs;

	assign dat_pin = drv_en ? drv_val : 1'bz;

	// ccitt crc, x^16 + x^12 + x^5 + 1, starting from zero, msb first
	function automatic logic [15:0] crc_of(input logic [31:0] w);
		logic [15:0] c;
		logic fb;
		c = '0;
		for (int k = 31; k >= 0; k--) begin
			fb = c[15] ^ w[k];
			c = {c[14:0], 1'b0} ^ (fb ? 16'h1021 : 16'h0000);
		end
		return c;
	endfunction

	// one bit per rising edge, highest index first
	task automatic drive_bits(input logic [49:0] bits, input int n);
		for (int k = n - 1; k >= 0; k--) begin
			drv_en <= 1'b1;
			drv_val <= bits[k];
			@(posedge sd_clock);
		end
		drv_en <= 1'b0;
	endtask

	task automatic take_writes();
		logic [31:0] w;
		logic [15:0] c;
		logic end_bit;
		logic [2:0] st;
		w = '0;
		c = '0;
		for (int i = 0; i < nblk; i++) begin
			while (dat_pin !== 1'b0 && !complete)
				@(negedge sd_clock);
			if (complete)
				break;
			for (int k = 0; k < 32; k++) begin
				@(negedge sd_clock);
				w = {w[30:0], dat_pin};
			end
			for (int k = 0; k < 16; k++) begin
				@(negedge sd_clock);
				c = {c[14:0], dat_pin};
			end
			@(negedge sd_clock);
			end_bit = dat_pin;
			if (c !== crc_of(w) || end_bit !== 1'b1)
				frame_errs++;
			rx_words[i] = w;
			frames_rx++;
			st = (mode == MODE_REJECT && i == bad_block) ? 3'b101 : `DAT_TOKEN_OK;
			// gap before the status token
			repeat (3) @(posedge sd_clock);
			drive_bits({42'd0, 1'b0, st, 4'hf}, `DAT_TOKEN_BITS);
		end
	endtask

	task automatic give_reads();
		logic [15:0] c;
		for (int i = 0; i < nblk; i++) begin
			while (!rx_window && !complete)
				@(negedge sd_clock);
			if (complete)
				break;
			repeat (2) @(posedge sd_clock);
			c = crc_of(tx_words[i]);
			if (mode == MODE_CORRUPT && i == bad_block)
				c = c ^ 16'h0001;
			drive_bits({1'b0, tx_words[i], c, 1'b1}, `DAT_FRAME_BITS);
			// host leaves the receive window before the next block
			while (rx_window && !complete)
				@(negedge sd_clock);
		end
	endtask

	initial begin
		drv_en = 1'b0;
		drv_val = 1'b1;
		frames_rx = 0;
		frame_errs = 0;
		forever begin
			@(posedge sd_clock);
			if (start) begin
				frames_rx = 0;
				frame_errs = 0;
				if (mode != MODE_SILENT) begin
					if (write_dir)
						take_writes();
					else
						give_reads();
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/dat_phys.sv
`timescale 1ns/1ps
`default_nettype none

module dat_phys (
	input wire sd_clock,
	input wire arst_n,
	input wire strobe_in,
	input wire ack_in,
	input wire idle_in,
	input wire sd_dat_pkg::timeout_t timeout_reg,
	input wire sd_dat_pkg::blk_count_t blocks,
	input wire write_read,
	input wire multiple,
	input wire status,
	input wire sd_dat_pkg::dat_word_t data_from_fifo,
	output logic serial_ready,
	output logic complete,
	output logic ack_out,
	output logic data_timeout,
	output logic crc_error,
	output logic read_enable,
	output logic write_enable,
	output sd_dat_pkg::dat_word_t data_to_fifo,
	inout wire dat_pin
);
	import sd_dat_pkg::*;

	host_cmd_t cmd;
	dat_word_t tx_word;
	rx_result_t rx_result;
	logic tx_load;
	logic tx_done;
	logic rx_enable;
	logic rx_token_mode;
	logic rx_started;
	logic rx_done;
	logic dat_out;
	logic dat_oe;
	logic dat_in;

	assign cmd = '{
		write_read: write_read,
		multiple: multiple,
		blocks: blocks,
		timeout: timeout_reg
	};

	// open drain style pad, the line idles high on the pullup
	assign dat_pin = dat_oe ? dat_out : 1'bz;
	assign dat_in = dat_pin;

	dat_phys_controller ctrl_inst (
		.sd_clock(sd_clock),
		.arst_n(arst_n),
		.strobe_in(strobe_in),
		.ack_in(ack_in),
		.idle_in(idle_in),
		.cmd(cmd),
		.status(status),
		.data_from_fifo(data_from_fifo),
		.tx_done(tx_done),
		.rx_started(rx_started),
		.rx_done(rx_done),
		.rx_result(rx_result),
		.serial_ready(serial_ready),
		.complete(complete),
		.ack_out(ack_out),
		.data_timeout(data_timeout),
		.crc_error(crc_error),
		.read_enable(read_enable),
		.write_enable(write_enable),
		.data_to_fifo(data_to_fifo),
		.tx_load(tx_load),
		.tx_word(tx_word),
		.rx_enable(rx_enable),
		.rx_token_mode(rx_token_mode)
	);

	dat_serializer ser_inst (
		.sd_clock(sd_clock),
		.arst_n(arst_n),
		.tx_load(tx_load),
		.tx_word(tx_word),
		.dat_out(dat_out),
		.dat_oe(dat_oe),
		.tx_done(tx_done)
	);

	dat_deserializer des_inst (
		.sd_clock(sd_clock),
		.arst_n(arst_n),
		.rx_enable(rx_enable),
		.rx_token_mode(rx_token_mode),
		.dat_in(dat_in),
		.rx_started(rx_started),
		.rx_done(rx_done),
		.rx_result(rx_result)
	);

endmodule

`default_nettype wire

// File: logic/dat_phys_controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "sd_dat_config.svh"

module dat_phys_controller (
	input wire sd_clock,
	input wire arst_n,
	input wire strobe_in,
	input wire ack_in,
	input wire idle_in,
	input wire sd_dat_pkg::host_cmd_t cmd,
	input wire status,
	input wire sd_dat_pkg::dat_word_t data_from_fifo,
	input wire tx_done,
	input wire rx_started,
	input wire rx_done,
	input wire sd_dat_pkg::rx_result_t rx_result,
	output logic serial_ready,
	output logic complete,
	output logic ack_out,
	output logic data_timeout,
	output logic crc_error,
	output logic read_enable,
	output logic write_enable,
	output sd_dat_pkg::dat_word_t data_to_fifo,
	output logic tx_load,
	output sd_dat_pkg::dat_word_t tx_word,
	output logic rx_enable,
	output logic rx_token_mode
);
	import sd_dat_pkg::*;

	ctrl_state_t state;
	host_cmd_t cmd_q;
	blk_count_t remaining;
	timeout_t tout_cnt;
	dat_word_t word_q;
	logic word_valid;
	// fifo data arrives the cycle after read_enable
	logic cap_q;
	logic last_block;
	logic tout_hit;

	assign serial_ready = (state == S_IDLE);
	assign complete = (state == S_DONE);
	assign rx_token_mode = (state == S_TOKEN);
	assign rx_enable = (state == S_TOKEN) || (state == S_WAIT_RX);
	assign tx_word = word_q;
	assign last_block = (remaining == blk_count_t'(1));
	assign tout_hit = rx_enable && !rx_started && (tout_cnt == cmd_q.timeout);

	// next word is prefetched while the token of the current block comes in
	assign read_enable = !word_valid && !cap_q && !status &&
		((state == S_FETCH) || (state == S_TOKEN && !last_block));
	assign write_enable = (state == S_STORE) && !status;

	always_ff @(posedge sd_clock or negedge arst_n) begin
		if (!arst_n) begin
			state <= S_IDLE;
			cmd_q <= '0;
			remaining <= '0;
			tout_cnt <= '0;
			word_valid <= 1'b0;
			cap_q <= 1'b0;
			ack_out <= 1'b0;
			data_timeout <= 1'b0;
			crc_error <= 1'b0;
			tx_load <= 1'b0;
		end else begin
			ack_out <= 1'b0;
			tx_load <= 1'b0;
			cap_q <= read_enable;
			if (cap_q)
				word_valid <= 1'b1;
			if (rx_enable && !rx_started)
				tout_cnt <= tout_cnt + 1'b1;

			if (idle_in) begin
				state <= S_IDLE;
				data_timeout <= 1'b0;
				crc_error <= 1'b0;
				word_valid <= 1'b0;
				cap_q <= 1'b0;
			end else if (tout_hit) begin
				data_timeout <= 1'b1;
				state <= S_DONE;
			end else begin
				case (state)
					S_IDLE: if (strobe_in) begin
						cmd_q <= cmd;
						// single block unless multiple with a nonzero count
						remaining <= (cmd.multiple && cmd.blocks != '0) ? cmd.blocks : 1'b1;
						tout_cnt <= '0;
						data_timeout <= 1'b0;
						crc_error <= 1'b0;
						word_valid <= 1'b0;
						state <= cmd.write_read ? S_FETCH : S_WAIT_RX;
					end
					S_FETCH: if (word_valid) begin
						tx_load <= 1'b1;
						word_valid <= 1'b0;
						state <= S_SEND;
					end
					S_SEND: if (tx_done) begin
						tout_cnt <= '0;
						state <= S_TOKEN;
					end
					S_TOKEN: if (rx_done) begin
						if (rx_result.token != `DAT_TOKEN_OK) begin
							crc_error <= 1'b1;
							state <= S_DONE;
						end else if (last_block) begin
							state <= S_DONE;
						end else begin
							remaining <= remaining - 1'b1;
							state <= S_FETCH;
						end
					end
					S_WAIT_RX: if (rx_done) begin
						if (!rx_result.crc_ok) begin
							crc_error <= 1'b1;
							state <= S_DONE;
						end else begin
							state <= S_STORE;
						end
					end
					S_STORE: if (!status) begin
						if (last_block) begin
							state <= S_DONE;
						end else begin
							remaining <= remaining - 1'b1;
							tout_cnt <= '0;
							state <= S_WAIT_RX;
						end
					end
					S_DONE: if (ack_in) begin
						ack_out <= 1'b1;
						state <= S_IDLE;
					end
					default: state <= S_IDLE;
				endcase
			end
		end
	end

	always_ff @(posedge sd_clock) begin
		if (cap_q)
			word_q <= data_from_fifo;
		if (state == S_WAIT_RX && rx_done)
			data_to_fifo <= rx_result.word;
	end

endmodule

`default_nettype wire

// File: logic/dat_deserializer.sv
`timescale 1ns/1ps
`default_nettype none

`include "sd_dat_config.svh"

module dat_deserializer (
	input wire sd_clock,
	input wire arst_n,
	input wire rx_enable,
	input wire rx_token_mode,
	input wire dat_in,
	output logic rx_started,
	output logic rx_done,
	output sd_dat_pkg::rx_result_t rx_result
);
	import sd_dat_pkg::*;

	localparam frame_len_t DATA_END = frame_len_t'(`DAT_WORD_BITS);
	localparam frame_len_t CRC_END = frame_len_t'(`DAT_WORD_BITS + `DAT_CRC_BITS);
	localparam frame_len_t FRAME_LAST = frame_len_t'(`DAT_FRAME_BITS - 2);
	localparam frame_len_t TOKEN_LAST = frame_len_t'(`DAT_TOKEN_BITS - 2);

	// bits after the start bit, counted from zero
	frame_len_t cnt;
	frame_len_t last;
	logic busy;
	logic start_seen;
	dat_word_t word_q;
	crc16_t crc_calc;
	crc16_t crc_rx;
	logic [2:0] token_q;
	logic crc_ok_q;

	assign last = rx_token_mode ? TOKEN_LAST : FRAME_LAST;
	assign start_seen = rx_enable && !rx_started && !dat_in;
	assign rx_result = '{word: word_q, token: token_q, crc_ok: crc_ok_q};

	always_ff @(posedge sd_clock or negedge arst_n) begin
		if (!arst_n) begin
			rx_started <= 1'b0;
			busy <= 1'b0;
			cnt <= '0;
			rx_done <= 1'b0;
		end else begin
			rx_done <= 1'b0;
			if (!rx_enable) begin
				// stays started until the controller lets go
				rx_started <= 1'b0;
				busy <= 1'b0;
			end else if (start_seen) begin
				rx_started <= 1'b1;
				busy <= 1'b1;
				cnt <= '0;
			end else if (busy) begin
				cnt <= cnt + 1'b1;
				if (cnt == last) begin
					busy <= 1'b0;
					rx_done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge sd_clock) begin
		if (start_seen) begin
			crc_calc <= '0;
		end else if (busy) begin
			if (rx_token_mode) begin
				// status bits follow the start bit
				if (cnt < 3'd3)
					token_q <= {token_q[1:0], dat_in};
			end else if (cnt < DATA_END) begin
				word_q <= {word_q[`DAT_WORD_BITS-2:0], dat_in};
				crc_calc <= crc16_step(crc_calc, dat_in);
			end else if (cnt < CRC_END) begin
				crc_rx <= {crc_rx[`DAT_CRC_BITS-2:0], dat_in};
			end
			// last bit is the end bit, must be high
			if (cnt == last)
				crc_ok_q <= dat_in && (rx_token_mode || crc_calc == crc_rx);
		end
	end

endmodule

`default_nettype wire

// File: logic/dat_serializer.sv
`timescale 1ns/1ps
`default_nettype none

`include "sd_dat_config.svh"

module dat_serializer (
	input wire sd_clock,
	input wire arst_n,
	input wire tx_load,
	input wire sd_dat_pkg::dat_word_t tx_word,
	output logic dat_out,
	output logic dat_oe,
	output logic tx_done
);
	import sd_dat_pkg::*;

	localparam frame_len_t DATA_END = frame_len_t'(`DAT_WORD_BITS);
	localparam frame_len_t CRC_END = frame_len_t'(`DAT_WORD_BITS + `DAT_CRC_BITS);
	localparam frame_len_t LAST_BIT = frame_len_t'(`DAT_FRAME_BITS - 1);

	dat_word_t shreg;
	crc16_t crc;
	// index of the bit currently on the line
	frame_len_t cnt;
	logic busy;

	always_ff @(posedge sd_clock or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
			cnt <= '0;
			dat_out <= 1'b1;
			dat_oe <= 1'b0;
			tx_done <= 1'b0;
		end else begin
			tx_done <= 1'b0;
			if (tx_load) begin
				// start bit goes out first
				busy <= 1'b1;
				cnt <= '0;
				dat_out <= 1'b0;
				dat_oe <= 1'b1;
			end else if (busy) begin
				cnt <= cnt + 1'b1;
				if (cnt == LAST_BIT) begin
					busy <= 1'b0;
					dat_oe <= 1'b0;
					dat_out <= 1'b1;
					tx_done <= 1'b1;
				end else if (cnt < DATA_END) begin
					dat_out <= shreg[`DAT_WORD_BITS-1];
				end else if (cnt < CRC_END) begin
					dat_out <= crc[`DAT_CRC_BITS-1];
				end else begin
					// end bit
					dat_out <= 1'b1;
				end
			end
		end
	end

	// crc is final when the last data bit leaves, then it is shifted out
	always_ff @(posedge sd_clock) begin
		if (tx_load) begin
			shreg <= tx_word;
			crc <= '0;
		end else if (busy) begin
			if (cnt < DATA_END) begin
				shreg <= {shreg[`DAT_WORD_BITS-2:0], 1'b0};
				crc <= crc16_step(crc, shreg[`DAT_WORD_BITS-1]);
			end else if (cnt < CRC_END) begin
				crc <= {crc[`DAT_CRC_BITS-2:0], 1'b0};
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/sd_dat_pkg.sv
`default_nettype none

`include "sd_dat_config.svh"

package sd_dat_pkg;

	typedef logic [`DAT_WORD_BITS-1:0] dat_word_t;
	typedef logic [`DAT_CRC_BITS-1:0] crc16_t;
	typedef logic [5:0] frame_len_t;
	typedef logic [`DAT_BLOCK_BITS-1:0] blk_count_t;
	typedef logic [`DAT_TIMEOUT_BITS-1:0] timeout_t;

	// write_read high selects a write (host to card)
	typedef struct packed {
		logic write_read;
		logic multiple;
		blk_count_t blocks;
		timeout_t timeout;
	} host_cmd_t;

	// crc_ok also covers the end bit
	typedef struct packed {
		dat_word_t word;
		logic [2:0] token;
		logic crc_ok;
	} rx_result_t;

	typedef enum logic [2:0] {
		S_IDLE,
		S_FETCH,
		S_SEND,
		S_TOKEN,
		S_WAIT_RX,
		S_STORE,
		S_DONE
	} ctrl_state_t;

	// one bit of x^16 + x^12 + x^5 + 1
	function automatic crc16_t crc16_step(input crc16_t crc, input logic bit_in);
		logic fb;
		crc16_t nxt;
		fb = crc[`DAT_CRC_BITS-1] ^ bit_in;
		nxt = {crc[`DAT_CRC_BITS-2:0], 1'b0};
		if (fb)
			nxt = nxt ^ 16'h1021;
		return nxt;
	endfunction

endpackage

`default_nettype wire

// File: logic/sd_dat_config.svh
`ifndef SD_DAT_CONFIG_SVH
`define SD_DAT_CONFIG_SVH

// data word carried by one block
`define DAT_WORD_BITS 32

// CCITT CRC over the data bits
`define DAT_CRC_BITS 16

// start bit + data + crc + end bit
`define DAT_FRAME_BITS 50

// status token from the card after a write, start bit included
`define DAT_TOKEN_BITS 8

`define DAT_BLOCK_BITS 4
`define DAT_TIMEOUT_BITS 16

// status bits of an accepted block
`define DAT_TOKEN_OK 3'b010

`endif
